// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f list.f --top-module processorci_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vprocessorci_tb +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: design/acc_core.sv
`timescale 1ns/10ps

module acc_core import harness_pkg::*; (
    input  logic  sys_clk,
    input  logic  core_rst_i,   // Synchronous, active high
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output logic  wb_we_o,
    output addr_t wb_addr_o,
    output word_t wb_data_o,
    input  word_t wb_data_i,
    input  logic  wb_ack_i,
    output logic  halted_o
);
    core_state_t state;
    logic [7:0]  pc;        // Word index of next instruction
    word_t       acc;
    word_t       ir;
    opcode_t     op;
    logic [7:0]  operand;

    assign op      = opcode_t'(ir[31:28]);
    assign operand = ir[7:0];

    always_ff @(posedge sys_clk) begin
        if (state == CORE_FETCH && wb_cyc_o && wb_ack_i) begin
            ir <= wb_data_i;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (core_rst_i) begin
            state     <= CORE_FETCH;
            pc        <= '0;
            acc       <= '0;
            halted_o  <= 1'b0;
            wb_cyc_o  <= 1'b0;
            wb_stb_o  <= 1'b0;
            wb_we_o   <= 1'b0;
            wb_addr_o <= '0;
            wb_data_o <= '0;
        end else begin
            case (state)
                CORE_FETCH: begin
                    if (!wb_cyc_o) begin
                        wb_cyc_o  <= 1'b1;
                        wb_stb_o  <= 1'b1;
                        wb_we_o   <= 1'b0;
                        wb_addr_o <= addr_t'({pc, 2'b00});
                    end else if (wb_ack_i) begin
                        wb_cyc_o <= 1'b0;
                        wb_stb_o <= 1'b0;
                        pc       <= pc + 8'd1;
                        state    <= CORE_EXEC;
                    end
                end

                CORE_EXEC: begin
                    case (op)
                        OP_LOAD, OP_ADD, OP_STORE: begin
                            if (!wb_cyc_o) begin
                                wb_cyc_o  <= 1'b1;
                                wb_stb_o  <= 1'b1;
                                wb_we_o   <= (op == OP_STORE);
                                wb_addr_o <= addr_t'({operand, 2'b00});
                                wb_data_o <= acc;
                            end else if (wb_ack_i) begin
                                wb_cyc_o <= 1'b0;
                                wb_stb_o <= 1'b0;
                                wb_we_o  <= 1'b0;
                                if (op == OP_LOAD) begin
                                    acc <= wb_data_i;
                                end else if (op == OP_ADD) begin
                                    acc <= acc + wb_data_i;   // Wraps at 32 bits
                                end
                                state <= CORE_FETCH;
                            end
                        end
                        OP_JMP: begin
                            pc    <= operand;
                            state <= CORE_FETCH;
                        end
                        OP_JZ: begin
                            if (acc == '0) begin
                                pc <= operand;
                            end
                            state <= CORE_FETCH;
                        end
                        OP_HALT: begin
                            halted_o <= 1'b1;
                            state    <= CORE_HALTED;
                        end
                        default: state <= CORE_FETCH;   // No-op
                    endcase
                end

                CORE_HALTED: ;   // Only the core reset leaves this state

                default: state <= CORE_FETCH;
            endcase
        end
    end

endmodule

// File: design/ci_controller.sv
`timescale 1ns/10ps
`include "harness_defs.svh"

module ci_controller import harness_pkg::*; (
    input  logic  sys_clk,
    input  logic  arst_n_i,

    // UART side
    input  byte_t rx_data_i,
    input  logic  rx_valid_i,
    output byte_t tx_data_o,
    output logic  tx_start_o,
    input  logic  tx_busy_i,

    // Core control
    input  logic  halted_i,
    output logic  core_rst_o,

    // Wishbone master, used only while the core is held
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output logic  wb_we_o,
    output addr_t wb_addr_o,
    output word_t wb_data_o,
    input  word_t wb_data_i,
    input  logic  wb_ack_i
);
    ctrl_state_t state;
    byte_t       cmd;
    logic [3:0]  byte_cnt;
    logic        last_byte;
    addr_t       addr_q;
    word_t       data_q;
    word_t       rsp_q;     // Reply bytes, MSB goes out first
    logic [2:0]  rsp_cnt;

    // R carries 4 payload bytes, W carries 8
    assign last_byte = (cmd == `CMD_READ) ? (byte_cnt == 4'd3) : (byte_cnt == 4'd7);

    always_ff @(posedge sys_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state      <= CTRL_IDLE;
            cmd        <= '0;
            byte_cnt   <= '0;
            addr_q     <= '0;
            data_q     <= '0;
            rsp_q      <= '0;
            rsp_cnt    <= '0;
            tx_data_o  <= '0;
            tx_start_o <= 1'b0;
            core_rst_o <= 1'b1;   // Core starts held
            wb_cyc_o   <= 1'b0;
            wb_stb_o   <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            tx_start_o <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    if (rx_valid_i) begin
                        case (rx_data_i)
                            `CMD_WRITE, `CMD_READ: begin
                                cmd      <= rx_data_i;
                                byte_cnt <= '0;
                                state    <= CTRL_ARGS;
                            end
                            `CMD_START: begin
                                core_rst_o <= 1'b0;
                                rsp_q      <= {`RSP_OK, 24'h0};
                                rsp_cnt    <= 3'd1;
                                state      <= CTRL_REPLY;
                            end
                            `CMD_HOLD: begin
                                core_rst_o <= 1'b1;
                                rsp_q      <= {`RSP_OK, 24'h0};
                                rsp_cnt    <= 3'd1;
                                state      <= CTRL_REPLY;
                            end
                            `CMD_POLL: begin
                                rsp_q   <= {7'd0, halted_i, 24'h0};
                                rsp_cnt <= 3'd1;
                                state   <= CTRL_REPLY;
                            end
                            default: ;   // Unknown bytes are dropped
                        endcase
                    end
                end

                CTRL_ARGS: begin
                    if (rx_valid_i) begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (byte_cnt < 4'd4) begin
                            addr_q <= {addr_q[23:0], rx_data_i};
                        end else begin
                            data_q <= {data_q[23:0], rx_data_i};
                        end
                        if (last_byte) begin
                            if (!core_rst_o) begin
                                // Memory belongs to the running core
                                rsp_q   <= {`RSP_ERR, 24'h0};
                                rsp_cnt <= 3'd1;
                                state   <= CTRL_REPLY;
                            end else begin
                                wb_cyc_o <= 1'b1;
                                wb_stb_o <= 1'b1;
                                wb_we_o  <= (cmd == `CMD_WRITE);
                                state    <= CTRL_BUS;
                            end
                        end
                    end
                end

                CTRL_BUS: begin
                    if (wb_ack_i) begin
                        wb_cyc_o <= 1'b0;
                        wb_stb_o <= 1'b0;
                        wb_we_o  <= 1'b0;
                        if (wb_we_o) begin
                            rsp_q   <= {`RSP_OK, 24'h0};
                            rsp_cnt <= 3'd1;
                        end else begin
                            rsp_q   <= wb_data_i;
                            rsp_cnt <= 3'd4;
                        end
                        state <= CTRL_REPLY;
                    end
                end

                CTRL_REPLY: begin
                    if (rsp_cnt == 3'd0) begin
                        state <= CTRL_IDLE;
                    end else if (!tx_busy_i && !tx_start_o) begin
                        // Busy rises a cycle late, hence the start check
                        tx_start_o <= 1'b1;
                        tx_data_o  <= rsp_q[31:24];
                        rsp_q      <= {rsp_q[23:0], 8'h00};
                        rsp_cnt    <= rsp_cnt - 3'd1;
                    end
                end

                default: state <= CTRL_IDLE;
            endcase
        end
    end

    assign wb_addr_o = addr_q;
    assign wb_data_o = data_q;

endmodule

// File: design/harness_defs.svh
`ifndef HARNESS_DEFS_SVH
`define HARNESS_DEFS_SVH

// Bus and memory geometry
`define BUS_WIDTH    32
`define MEM_WORDS    256

// UART bit period in sys_clk cycles
`define CLKS_PER_BIT 8

// Host command bytes
`define CMD_WRITE    8'h57
`define CMD_READ     8'h52
`define CMD_START    8'h53
`define CMD_HOLD     8'h48
`define CMD_POLL     8'h50

// Reply bytes
`define RSP_OK       8'h4B
`define RSP_ERR      8'h45

`endif

// File: design/harness_pkg.sv
`include "harness_defs.svh"

package harness_pkg;

    typedef logic [`BUS_WIDTH-1:0] word_t;  // Data word on the bus
    typedef logic [`BUS_WIDTH-1:0] addr_t;  // Byte address of which bits 9:2 pick the word
    typedef logic [7:0]            byte_t;  // UART payload

    // Instruction bits 31:28, anything not listed is a no-op
    typedef enum logic [3:0] {
        OP_LOAD  = 4'd1,
        OP_ADD   = 4'd2,
        OP_STORE = 4'd3,
        OP_JMP   = 4'd4,
        OP_JZ    = 4'd5,
        OP_HALT  = 4'd15
    } opcode_t;

    // Host command decoder
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ARGS,   // Collecting address and data bytes
        CTRL_BUS,
        CTRL_REPLY
    } ctrl_state_t;

    typedef enum logic [1:0] {
        CORE_FETCH,
        CORE_EXEC,
        CORE_HALTED
    } core_state_t;

endpackage

// File: design/processorci_top.sv
`timescale 1ns/10ps

module processorci_top import harness_pkg::*; (
    input  logic sys_clk,
    input  logic arst_n_i,
    input  logic rx_i,
    output logic tx_o
);
    byte_t rx_data;
    logic  rx_valid;
    byte_t tx_data;
    logic  tx_start;
    logic  tx_busy;
    logic  core_rst;
    logic  halted;

    // Controller side of the bus
    logic  ctl_cyc;
    logic  ctl_stb;
    logic  ctl_we;
    addr_t ctl_addr;
    word_t ctl_wdata;
    logic  ctl_ack;

    // Core side of the bus
    logic  cpu_cyc;
    logic  cpu_stb;
    logic  cpu_we;
    addr_t cpu_addr;
    word_t cpu_wdata;
    logic  cpu_ack;

    // Memory side of the bus
    logic  mem_cyc;
    logic  mem_stb;
    logic  mem_we;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_ack;

    // Controller owns the bus while the core is held
    assign mem_cyc   = core_rst ? ctl_cyc   : cpu_cyc;
    assign mem_stb   = core_rst ? ctl_stb   : cpu_stb;
    assign mem_we    = core_rst ? ctl_we    : cpu_we;
    assign mem_addr  = core_rst ? ctl_addr  : cpu_addr;
    assign mem_wdata = core_rst ? ctl_wdata : cpu_wdata;
    assign ctl_ack   = mem_ack &  core_rst;
    assign cpu_ack   = mem_ack & ~core_rst;

    uart_rx u_uart_rx (
        .sys_clk    (sys_clk),
        .arst_n_i   (arst_n_i),
        .rx_i       (rx_i),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid)
    );

    uart_tx u_uart_tx (
        .sys_clk    (sys_clk),
        .arst_n_i   (arst_n_i),
        .tx_start_i (tx_start),
        .tx_data_i  (tx_data),
        .tx_o       (tx_o),
        .tx_busy_o  (tx_busy)
    );

    ci_controller u_ci_controller (
        .sys_clk    (sys_clk),
        .arst_n_i   (arst_n_i),
        .rx_data_i  (rx_data),
        .rx_valid_i (rx_valid),
        .tx_data_o  (tx_data),
        .tx_start_o (tx_start),
        .tx_busy_i  (tx_busy),
        .halted_i   (halted),
        .core_rst_o (core_rst),
        .wb_cyc_o   (ctl_cyc),
        .wb_stb_o   (ctl_stb),
        .wb_we_o    (ctl_we),
        .wb_addr_o  (ctl_addr),
        .wb_data_o  (ctl_wdata),
        .wb_data_i  (mem_rdata),
        .wb_ack_i   (ctl_ack)
    );

    wb_memory u_wb_memory (
        .sys_clk    (sys_clk),
        .arst_n_i   (arst_n_i),
        .wb_cyc_i   (mem_cyc),
        .wb_stb_i   (mem_stb),
        .wb_we_i    (mem_we),
        .wb_addr_i  (mem_addr),
        .wb_data_i  (mem_wdata),
        .wb_data_o  (mem_rdata),
        .wb_ack_o   (mem_ack)
    );

    acc_core u_acc_core (
        .sys_clk    (sys_clk),
        .core_rst_i (core_rst),
        .wb_cyc_o   (cpu_cyc),
        .wb_stb_o   (cpu_stb),
        .wb_we_o    (cpu_we),
        .wb_addr_o  (cpu_addr),
        .wb_data_o  (cpu_wdata),
        .wb_data_i  (mem_rdata),
        .wb_ack_i   (cpu_ack),
        .halted_o   (halted)
    );

endmodule

// File: design/uart_rx.sv
`timescale 1ns/10ps
`include "harness_defs.svh"

module uart_rx import harness_pkg::*; (
    input  logic  sys_clk,
    input  logic  arst_n_i,
    input  logic  rx_i,
    output byte_t rx_data_o,
    output logic  rx_valid_o
);
    localparam int CW = $clog2(`CLKS_PER_BIT);
    localparam logic [CW-1:0] HALF_BIT = CW'(`CLKS_PER_BIT / 2 - 1);
    localparam logic [CW-1:0] FULL_BIT = CW'(`CLKS_PER_BIT - 1);

    logic          rx_meta;
    logic          rx_sync;
    logic          busy;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_idx;   // 0 start, 1..8 data, 9 stop
    byte_t         shift_q;

    // Line idles high
    always_ff @(posedge sys_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy       <= 1'b0;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (!busy) begin
                if (!rx_sync) begin   // Possible start bit
                    busy    <= 1'b1;
                    clk_cnt <= '0;
                    bit_idx <= '0;
                end
            end else if (bit_idx == 4'd0) begin
                if (clk_cnt == HALF_BIT) begin
                    clk_cnt <= '0;
                    if (rx_sync) begin
                        busy <= 1'b0;   // Glitch, back to idle
                    end else begin
                        bit_idx <= 4'd1;
                    end
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
            end else if (clk_cnt == FULL_BIT) begin
                clk_cnt <= '0;
                if (bit_idx == 4'd9) begin
                    busy       <= 1'b0;
                    rx_valid_o <= rx_sync;   // Framing check on stop bit
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // LSB arrives first
    always_ff @(posedge sys_clk) begin
        if (busy && bit_idx != 4'd0 && bit_idx != 4'd9 && clk_cnt == FULL_BIT) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

    assign rx_data_o = shift_q;

endmodule

// File: design/uart_tx.sv
`timescale 1ns/10ps
`include "harness_defs.svh"

module uart_tx import harness_pkg::*; (
    input  logic  sys_clk,
    input  logic  arst_n_i,
    input  logic  tx_start_i,
    input  byte_t tx_data_i,
    output logic  tx_o,
    output logic  tx_busy_o
);
    localparam int CW = $clog2(`CLKS_PER_BIT);
    localparam logic [CW-1:0] FULL_BIT = CW'(`CLKS_PER_BIT - 1);

    logic [9:0]    frame_q;   // Stop, data, start with LSB on the line
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bits_left;

    always_ff @(posedge sys_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            frame_q   <= '1;
            tx_busy_o <= 1'b0;
            clk_cnt   <= '0;
            bits_left <= '0;
        end else if (!tx_busy_o) begin
            if (tx_start_i) begin
                frame_q   <= {1'b1, tx_data_i, 1'b0};
                tx_busy_o <= 1'b1;
                clk_cnt   <= '0;
                bits_left <= 4'd10;
            end
        end else if (clk_cnt == FULL_BIT) begin
            clk_cnt   <= '0;
            frame_q   <= {1'b1, frame_q[9:1]};   // Refill with idle level
            bits_left <= bits_left - 4'd1;
            if (bits_left == 4'd1) begin
                tx_busy_o <= 1'b0;   // Stop bit done
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    assign tx_o = frame_q[0];

endmodule

// File: design/wb_memory.sv
`timescale 1ns/10ps
`include "harness_defs.svh"

module wb_memory import harness_pkg::*; (
    input  logic  sys_clk,
    input  logic  arst_n_i,
    input  logic  wb_cyc_i,
    input  logic  wb_stb_i,
    input  logic  wb_we_i,
    input  addr_t wb_addr_i,
    input  word_t wb_data_i,
    output word_t wb_data_o,
    output logic  wb_ack_o
);
    localparam int AW = $clog2(`MEM_WORDS);

    word_t         mem [`MEM_WORDS];
    logic [AW-1:0] word_idx;
    logic          req;

    assign word_idx = wb_addr_i[AW+1:2];   // Byte address to word index
    assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o;

    // One-cycle ack, drops even if stb is still high
    always_ff @(posedge sys_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (req) begin
            if (wb_we_i) begin
                mem[word_idx] <= wb_data_i;
            end
            wb_data_o <= mem[word_idx];   // Valid together with ack
        end
    end

endmodule

// File: list.f
+incdir+design
design/harness_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/ci_controller.sv
design/wb_memory.sv
design/acc_core.sv
design/processorci_top.sv
verification/processorci_chk.sv
verification/processorci_tb.sv

// File: verification/processorci_chk.sv
`timescale 1ns/10ps

module processorci_chk (
    input logic sys_clk,
    input logic arst_n_i,
    input logic tx_i,
    input logic core_rst_i,
    input logic ctl_cyc_i,
    input logic mem_cyc_i,
    input logic mem_stb_i,
    input logic mem_ack_i
);
    int fail_cnt = 0;   // Number of failed properties so far

    // Memory only acks an open cycle
    ack_in_cycle: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
        mem_ack_i |-> (mem_cyc_i && mem_stb_i))
    else begin
        fail_cnt++;
        $error("Memory ack seen without cyc and stb");
    end

    // Master keeps stb up until ack
    stb_held: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
        (mem_stb_i && !mem_ack_i) |=> mem_stb_i)
    else begin
        fail_cnt++;
        $error("stb dropped before ack");
    end

    // UART line idles high from the second reset cycle on
    tx_idle_in_reset: assert property (@(posedge sys_clk)
        !arst_n_i |=> tx_i)
    else begin
        fail_cnt++;
        $error("tx line not idle during reset");
    end

    ctl_quiet_while_running: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
        !core_rst_i |-> !ctl_cyc_i)
    else begin
        fail_cnt++;
        $error("Controller opened a bus cycle while the core runs");
    end

endmodule

bind processorci_top processorci_chk chk0 (
    .sys_clk    (sys_clk),
    .arst_n_i   (arst_n_i),
    .tx_i       (tx_o),
    .core_rst_i (core_rst),
    .ctl_cyc_i  (ctl_cyc),
    .mem_cyc_i  (mem_cyc),
    .mem_stb_i  (mem_stb),
    .mem_ack_i  (mem_ack)
);

// File: verification/processorci_tb.sv
`timescale 1ns/10ps
`include "harness_defs.svh"

module processorci_tb import harness_pkg::*; ();
    localparam int CLK_PERIOD  = 20;
    localparam int BYTE_NS     = 10 * `CLKS_PER_BIT * CLK_PERIOD;
    localparam int TEST_BYTES  = 330;   // UART bytes both ways over the whole sequence
    localparam int WATCHDOG_NS = 2 * TEST_BYTES * BYTE_NS;

    logic   sys_clk = 1'b0;
    logic   arst_n_i;
    logic   rx_i;
    logic   tx_o;
    integer seed = 8687;

    processorci_top dut0 (
        .sys_clk  (sys_clk),
        .arst_n_i (arst_n_i),
        .rx_i     (rx_i),
        .tx_o     (tx_o)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic expect_byte(input string name, input byte_t exp, input byte_t act);
        assert (act === exp)
        else abort_run($sformatf("CHECK FAILED: %s expected %02h actual %02h", name, exp, act));
    endtask

    task automatic expect_word(input string name, input word_t exp, input word_t act);
        assert (act === exp)
        else abort_run($sformatf("CHECK FAILED: %s expected %08h actual %08h", name, exp, act));
    endtask

    function automatic addr_t word_addr(input logic [7:0] idx);
        return {22'd0, idx, 2'b00};
    endfunction

    function automatic word_t instr(input opcode_t op, input logic [7:0] idx);
        return {op, 20'd0, idx};
    endfunction

    // Spread the first test over the upper half of memory
    function automatic logic [7:0] spread_index(input int n);
        return 8'h80 + 8'(n * 29);
    endfunction

    task automatic send_bit(input logic v);
        @(posedge sys_clk);
        rx_i <= v;
        repeat (`CLKS_PER_BIT - 1) @(posedge sys_clk);
    endtask

    task automatic send_byte(input byte_t b);
        byte_t sh;
        sh = b;
        send_bit(1'b0);
        repeat (8) begin   // LSB first
            send_bit(sh[0]);
            sh = {1'b0, sh[7:1]};
        end
        send_bit(1'b1);
    endtask

    task automatic send_word(input word_t w);
        send_byte(w[31:24]);
        send_byte(w[23:16]);
        send_byte(w[15:8]);
        send_byte(w[7:0]);
    endtask

    // Samples mid-bit on the falling clock edge
    task automatic recv_byte(output byte_t b);
        @(negedge sys_clk);
        while (tx_o !== 1'b0) @(negedge sys_clk);
        repeat (`CLKS_PER_BIT / 2) @(negedge sys_clk);
        repeat (8) begin
            repeat (`CLKS_PER_BIT) @(negedge sys_clk);
            b = {tx_o, b[7:1]};
        end
        repeat (`CLKS_PER_BIT) @(negedge sys_clk);
        assert (tx_o === 1'b1)
        else abort_run("Stop bit missing on tx_o");
    endtask

    task automatic simple_cmd(input byte_t cmd, input byte_t exp, input string name);
        byte_t r;
        send_byte(cmd);
        recv_byte(r);
        expect_byte(name, exp, r);
    endtask

    task automatic mem_write(input logic [7:0] idx, input word_t data, input byte_t exp,
                             input string name);
        byte_t r;
        send_byte(`CMD_WRITE);
        send_word(word_addr(idx));
        send_word(data);
        recv_byte(r);
        expect_byte(name, exp, r);
    endtask

    task automatic mem_read_check(input logic [7:0] idx, input word_t exp, input string name);
        byte_t b;
        word_t w;
        send_byte(`CMD_READ);
        send_word(word_addr(idx));
        repeat (4) begin   // MSB first
            recv_byte(b);
            w = {w[23:0], b};
        end
        expect_word(name, exp, w);
    endtask

    task automatic mem_read_rejected(input logic [7:0] idx, input string name);
        byte_t r;
        send_byte(`CMD_READ);
        send_word(word_addr(idx));
        recv_byte(r);
        expect_byte(name, `RSP_ERR, r);
    endtask

    task automatic wait_halted(input string name);
        byte_t r;
        int    tries;
        r     = 8'h00;
        tries = 0;
        while (r != 8'h01 && tries < 8) begin
            send_byte(`CMD_POLL);
            recv_byte(r);
            tries++;
        end
        expect_byte(name, 8'h01, r);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("Timeout after %0d ns without the sequence finishing", WATCHDOG_NS));
    end

    always @(negedge sys_clk) begin
        if (dut0.chk0.fail_cnt != 0) begin
            abort_run("Bus or reset protocol assertion failed");
        end
    end

    initial begin
        word_t      b1_data [$];
        word_t      keep_word;
        logic [7:0] keep_idx;
        word_t      w;
        word_t      op_a;
        word_t      op_b;
        word_t      marker;
        word_t      val;
        word_t      late;
        int         n;

        arst_n_i = 1'b0;
        rx_i     = 1'b1;
        repeat (3) @(posedge sys_clk);
        arst_n_i <= 1'b1;
        repeat (4) @(posedge sys_clk);

        // 1. Plain write and readback
        for (n = 0; n < 4; n++) begin
            w = $random(seed);
            b1_data.push_back(w);
            mem_write(spread_index(n), w, `RSP_OK, "write ack");
        end
        for (n = 0; n < 4; n++) begin
            w = b1_data.pop_front();
            if (n == 2) begin
                keep_word = w;
                keep_idx  = spread_index(n);
            end
            mem_read_check(spread_index(n), w, "readback");
        end

        // 2. LOAD, ADD, STORE, HALT
        op_a = $random(seed);
        op_b = $random(seed);
        mem_write(8'h00, instr(OP_LOAD, 8'h40), `RSP_OK, "sum program");
        mem_write(8'h01, instr(OP_ADD, 8'h41), `RSP_OK, "sum program");
        mem_write(8'h02, instr(OP_STORE, 8'h42), `RSP_OK, "sum program");
        mem_write(8'h03, instr(OP_HALT, 8'h00), `RSP_OK, "sum program");
        mem_write(8'h40, op_a, `RSP_OK, "sum operand a");
        mem_write(8'h41, op_b, `RSP_OK, "sum operand b");
        simple_cmd(`CMD_START, `RSP_OK, "sum start");
        wait_halted("sum halt poll");
        simple_cmd(`CMD_HOLD, `RSP_OK, "sum hold");
        w = op_a + op_b;
        mem_read_check(8'h42, w, "sum result");

        // 3. Branches skip two stores to 0x51
        marker = $random(seed);
        val    = $random(seed) | 32'h1;   // Never zero
        mem_write(8'h00, instr(OP_JZ, 8'h02), `RSP_OK, "branch program");
        mem_write(8'h01, instr(OP_STORE, 8'h51), `RSP_OK, "branch program");
        mem_write(8'h02, instr(OP_LOAD, 8'h52), `RSP_OK, "branch program");
        mem_write(8'h03, instr(OP_JMP, 8'h05), `RSP_OK, "branch program");
        mem_write(8'h04, instr(OP_STORE, 8'h51), `RSP_OK, "branch program");
        mem_write(8'h05, instr(OP_STORE, 8'h53), `RSP_OK, "branch program");
        mem_write(8'h06, instr(OP_HALT, 8'h00), `RSP_OK, "branch program");
        mem_write(8'h51, marker, `RSP_OK, "branch marker");
        mem_write(8'h52, val, `RSP_OK, "branch value");
        mem_write(8'h53, ~val, `RSP_OK, "branch target");
        simple_cmd(`CMD_START, `RSP_OK, "branch start");
        wait_halted("branch halt poll");
        simple_cmd(`CMD_HOLD, `RSP_OK, "branch hold");
        mem_read_check(8'h51, marker, "skipped store");
        mem_read_check(8'h53, val, "taken store");

        // 4. Memory commands refused while the core runs
        late = $random(seed);
        simple_cmd(`CMD_START, `RSP_OK, "busy start");
        mem_write(8'h60, late, `RSP_ERR, "write while running");
        mem_read_rejected(8'h60, "read while running");
        simple_cmd(`CMD_HOLD, `RSP_OK, "busy hold");
        mem_write(8'h60, late, `RSP_OK, "write after hold");
        mem_read_check(8'h60, late, "readback after hold");

        // 5. Poll while held, then a byte that is no command
        simple_cmd(`CMD_POLL, 8'h00, "poll while held");
        send_byte(8'h5A);
        mem_read_check(keep_idx, keep_word, "read after stray byte");

        repeat (4) @(posedge sys_clk);
        if (dut0.chk0.fail_cnt == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("Bus or reset protocol assertion failed");
        end
    end

endmodule
